/* Bender.yml */
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/cache_ifs.sv
  - source/fetch_request.sv
  - source/tag_store.sv
  - source/line_store.sv
  - source/refill_master.sv
  - source/word_select.sv
  - source/icache_top.sv
  - target: simulation
    files:
      - bench/wb_memory_model.sv
      - bench/tb_icache.sv

/* bench/tb_icache.sv */
module tb_icache;

	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic req_valid;
	icache_pkg::addr_t req_addr;
	logic req_ready;
	logic flush;
	logic inst_valid;
	icache_pkg::word_t inst;
	logic inst_ready;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	icache_pkg::addr_t wb_adr;
	icache_pkg::word_t wb_dat_i;
	logic wb_ack;
	logic [3:0] wb_sel;
	int unsigned bus_cycles;
	icache_pkg::addr_t bus_addrs [$];

	icache_top icache_top_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.flush(flush),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_ready(inst_ready),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.wb_sel(wb_sel)
	);

	wb_memory_model memory_i (
		.clk(clk),
		.rst(rst),
		.cyc(wb_cyc),
		.stb(wb_stb),
		.adr(wb_adr),
		.dat_o(wb_dat_i),
		.ack(wb_ack),
		.cycle_count(bus_cycles)
	);

	always #5 clk = ~clk;

	function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
		return {addr[31:2], 2'b00} ^ 32'hC0DE_0000;
	endfunction

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
			abort_run();
		end
	endtask

	// Acked beats are logged mid-cycle where the bus is stable
	always @(negedge clk) begin
		if (wb_cyc && wb_stb && wb_ack) begin
			assert (!wb_we && wb_sel == 4'hF) else begin
				$display("bus beat at %h is not a full-width read", wb_adr);
				abort_run();
			end
			bus_addrs.push_back(wb_adr);
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ready(input string test);
		int n;
		n = 0;
		while (!req_ready) begin
			next_cycle();
			n++;
			if (n > TIMEOUT) begin
				$display("%s: req_ready stayed low for %0d cycles", test, TIMEOUT);
				abort_run();
			end
		end
	endtask

	task automatic send_request(input string test, input icache_pkg::addr_t addr);
		wait_ready(test);
		req_valid = 1'b1;
		req_addr = addr;
		next_cycle();
		req_valid = 1'b0;
	endtask

	// Counts the edges from the accepting edge up to inst_valid
	task automatic wait_response(input string test, output int edges);
		edges = 0;
		while (!inst_valid) begin
			next_cycle();
			edges++;
			if (edges > TIMEOUT) begin
				$display("%s: no instruction within %0d cycles", test, TIMEOUT);
				abort_run();
			end
		end
	endtask

	task automatic fetch_word(input string test, input icache_pkg::addr_t addr,
		output int edges, output int cycles);
		int unsigned start;
		start = bus_cycles;
		send_request(test, addr);
		wait_response(test, edges);
		check_value(test, "inst", expected_word(addr), inst);
		// inst_ready is high, so this edge consumes the word
		next_cycle();
		check_value(test, "inst_valid after consume", 32'd0, inst_valid);
		cycles = bus_cycles - start;
	endtask

	task automatic test_cold_miss();
		int edges;
		int cycles;
		int first;
		first = bus_addrs.size();
		fetch_word("cold_miss", 32'h0000_1234, edges, cycles);
		check_value("cold_miss", "bus cycles", 32'd4, cycles);
		for (int i = 0; i < 4; i++) begin
			check_value("cold_miss", "beat address", 32'h0000_1230 + 4 * i, bus_addrs[first + i]);
		end
	endtask

	task automatic test_hit();
		icache_pkg::addr_t addrs [3];
		int edges;
		int cycles;
		addrs = '{32'h0000_1230, 32'h0000_1238, 32'h0000_123C};
		foreach (addrs[i]) begin
			fetch_word("hit", addrs[i], edges, cycles);
			check_value("hit", "bus cycles", 32'd0, cycles);
			check_value("hit", "edges to inst_valid", 32'd3, edges);
		end
	endtask

	// Five tags share set 5 and the rotating victim pointer evicts the first one
	task automatic test_replacement();
		icache_pkg::addr_t lines [5];
		int edges;
		int cycles;
		for (int i = 0; i < 5; i++) begin
			lines[i] = 32'h0004_0058 + 32'h400 * i;
			fetch_word("replacement", lines[i], edges, cycles);
			check_value("replacement", "bus cycles of cold line", 32'd4, cycles);
		end
		fetch_word("replacement", lines[0], edges, cycles);
		check_value("replacement", "bus cycles of evicted line", 32'd4, cycles);
		fetch_word("replacement", lines[2], edges, cycles);
		check_value("replacement", "bus cycles of kept line", 32'd0, cycles);
		check_value("replacement", "edges to inst_valid", 32'd3, edges);
	endtask

	task automatic test_back_pressure();
		icache_pkg::addr_t addr;
		int edges;
		addr = 32'h0000_1238;
		inst_ready = 1'b0;
		send_request("back_pressure", addr);
		wait_response("back_pressure", edges);
		check_value("back_pressure", "inst", expected_word(addr), inst);
		repeat (6) begin
			next_cycle();
			check_value("back_pressure", "inst_valid under stall", 32'd1, inst_valid);
			check_value("back_pressure", "inst under stall", expected_word(addr), inst);
			check_value("back_pressure", "req_ready under stall", 32'd0, req_ready);
		end
		inst_ready = 1'b1;
		next_cycle();
		check_value("back_pressure", "inst_valid after consume", 32'd0, inst_valid);
		check_value("back_pressure", "req_ready after consume", 32'd1, req_ready);
	endtask

	task automatic test_flush();
		int edges;
		int cycles;
		int n;
		int unsigned start;
		start = bus_cycles;
		send_request("flush", 32'h0000_8A44);
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		n = 0;
		while (!req_ready) begin
			check_value("flush", "inst_valid of abandoned request", 32'd0, inst_valid);
			next_cycle();
			n++;
			if (n > TIMEOUT) begin
				$display("flush: tracker did not return to idle");
				abort_run();
			end
		end
		check_value("flush", "inst_valid of abandoned request", 32'd0, inst_valid);
		check_value("flush", "bus cycles of abandoned refill", 32'd4, bus_cycles - start);
		// The refill went on, so the same line now hits
		fetch_word("flush", 32'h0000_8A44, edges, cycles);
		check_value("flush", "bus cycles after refill", 32'd0, cycles);
		check_value("flush", "edges to inst_valid", 32'd3, edges);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		flush = 1'b0;
		inst_ready = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		check_value("reset", "req_ready", 32'd1, req_ready);
		check_value("reset", "inst_valid", 32'd0, inst_valid);
		check_value("reset", "wb_cyc", 32'd0, wb_cyc);
		check_value("reset", "wb_stb", 32'd0, wb_stb);
		test_cold_miss();
		test_hit();
		test_replacement();
		test_back_pressure();
		test_flush();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* bench/wb_memory_model.sv */
module wb_memory_model (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input icache_pkg::addr_t adr,
	output icache_pkg::word_t dat_o,
	output logic ack,
	output int unsigned cycle_count
);

	integer seed = 58567;
	integer draw;
	// Wait states left before the current strobe is acked
	logic [1:0] wait_left;

	// Memory content is a fixed function of the whole byte address
	function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
		return a ^ 32'hC0DE_0000;
	endfunction

	initial begin
		ack = 1'b0;
		dat_o = '0;
		cycle_count = 0;
		wait_left = '0;
	end

	// Bus outputs change one time unit after the edge like the other stimulus
	always @(posedge clk) begin
		if (rst) begin
			ack <= #1 1'b0;
			cycle_count <= 0;
			draw = $random(seed);
			wait_left <= draw[1:0];
		end else if (ack) begin
			// One beat ends here and the next one gets a fresh delay
			ack <= #1 1'b0;
			draw = $random(seed);
			wait_left <= draw[1:0];
		end else if (cyc && stb) begin
			if (wait_left == 2'd0) begin
				ack <= #1 1'b1;
				dat_o <= #1 mem_word(adr);
				cycle_count <= cycle_count + 1;
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

/* build.f */
source/icache_pkg.sv
source/cache_ifs.sv
source/fetch_request.sv
source/tag_store.sv
source/line_store.sv
source/refill_master.sv
source/word_select.sv
source/icache_top.sv
bench/wb_memory_model.sv
bench/tb_icache.sv

/* source/cache_ifs.sv */
// Tag lookup between the request tracker and the tag store
interface lookup_if;
	logic lookup_valid;
	icache_pkg::index_t index;
	icache_pkg::tag_t tag;
	icache_pkg::way_mask_t hit_way;
	logic miss;

	modport requester (
		output lookup_valid,
		output index,
		output tag,
		input hit_way,
		input miss
	);

	modport responder (
		input lookup_valid,
		input index,
		input tag,
		output hit_way,
		output miss
	);
endinterface

// Line fill from the refill master into both stores
interface fill_if;
	logic fill_valid;
	icache_pkg::index_t fill_index;
	icache_pkg::tag_t fill_tag;
	icache_pkg::line_t fill_line;
	icache_pkg::way_mask_t victim_way;

	modport master (
		output fill_valid,
		output fill_index,
		output fill_tag,
		output fill_line
	);

	// The tag store also owns the victim choice
	modport tag (
		input fill_valid,
		input fill_index,
		input fill_tag,
		output victim_way
	);

	modport line (
		input fill_valid,
		input fill_index,
		input fill_line,
		input victim_way
	);
endinterface

/* source/fetch_request.sv */
module fetch_request (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input icache_pkg::addr_t req_addr,
	output logic req_ready,
	input logic flush,
	lookup_if.requester lookup,
	output logic refill_start,
	output icache_pkg::addr_t refill_addr,
	input logic refill_done,
	input logic inst_valid,
	input logic inst_ready,
	output logic take,
	output logic use_fill,
	output icache_pkg::way_mask_t sel_way,
	output icache_pkg::offset_t offset
);

	icache_pkg::req_state_t state;
	icache_pkg::addr_t addr_q;
	logic cancel;
	// Respond phase 0 waits for the line read, 1 takes the word and 2 waits for the consumer
	logic [1:0] stage;

	assign req_ready = (state == icache_pkg::req_idle);

	assign lookup.lookup_valid = (state == icache_pkg::req_lookup);
	assign lookup.index = addr_q[9:4];
	assign lookup.tag = addr_q[31:10];
	assign offset = addr_q[3:2];

	// A miss always starts its refill and a flush only cancels the response
	assign refill_start = lookup.miss;
	assign refill_addr = addr_q;

	assign take = (state == icache_pkg::req_respond) && (stage == 2'd1);

	always_ff @(posedge clk) begin
		if (req_ready && req_valid) begin
			addr_q <= req_addr;
		end
		if (state == icache_pkg::req_lookup) begin
			sel_way <= lookup.hit_way;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_pkg::req_idle;
			cancel <= 1'b0;
			stage <= 2'd0;
			use_fill <= 1'b0;
		end else begin
			case (state)
				icache_pkg::req_idle: begin
					cancel <= 1'b0;
					if (req_valid) begin
						state <= icache_pkg::req_lookup;
					end
				end
				icache_pkg::req_lookup: begin
					if (lookup.miss) begin
						state <= icache_pkg::req_refill;
						use_fill <= 1'b1;
						cancel <= flush;
					end else if (flush) begin
						state <= icache_pkg::req_idle;
					end else begin
						state <= icache_pkg::req_respond;
						stage <= 2'd0;
						use_fill <= 1'b0;
					end
				end
				icache_pkg::req_refill: begin
					if (flush) begin
						cancel <= 1'b1;
					end
					// The line is written to the stores on this same edge
					if (refill_done) begin
						if (cancel || flush) begin
							state <= icache_pkg::req_idle;
						end else begin
							state <= icache_pkg::req_respond;
							stage <= 2'd0;
						end
					end
				end
				icache_pkg::req_respond: begin
					if (flush) begin
						state <= icache_pkg::req_idle;
					end else if (stage != 2'd2) begin
						stage <= stage + 2'd1;
					end else if (inst_valid && inst_ready) begin
						state <= icache_pkg::req_idle;
					end
				end
				default: begin
					state <= icache_pkg::req_idle;
				end
			endcase
		end
	end

endmodule

/* source/icache_pkg.sv */
package icache_pkg;

	// Byte address as presented by the fetch unit
	typedef logic [31:0] addr_t;

	// Address fields of a 64-set cache with 16-byte lines
	typedef logic [21:0] tag_t;
	typedef logic [5:0] index_t;
	typedef logic [1:0] offset_t;

	// Instruction word and the width of one bus beat
	typedef logic [31:0] word_t;

	// One cache line with word 0 in the low bits
	typedef logic [127:0] line_t;

	// One-hot way mask that is all zero when no way is meant
	typedef logic [3:0] way_mask_t;

	// Request tracker states
	typedef enum logic [1:0] {
		req_idle,
		req_lookup,
		req_refill,
		req_respond
	} req_state_t;

	localparam int WAY_COUNT_DEFAULT = 4;

	// Bus beats needed to move one line
	localparam int LINE_BEATS = 4;

	// Number of sets follows from the index width
	localparam int SET_COUNT = 2 ** $bits(index_t);

endpackage

/* source/icache_top.sv */
module icache_top #(
	parameter int WAY_COUNT = icache_pkg::WAY_COUNT_DEFAULT
) (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input icache_pkg::addr_t req_addr,
	output logic req_ready,
	input logic flush,
	output logic inst_valid,
	output icache_pkg::word_t inst,
	input logic inst_ready,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output icache_pkg::addr_t wb_adr,
	input icache_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output logic [3:0] wb_sel
);

	lookup_if lookup_bus ();
	fill_if fill_bus ();

	logic refill_start;
	icache_pkg::addr_t refill_addr;
	logic refill_done;
	logic take;
	logic use_fill;
	icache_pkg::way_mask_t sel_way;
	icache_pkg::offset_t offset;
	icache_pkg::line_t rd_lines [WAY_COUNT];

	fetch_request fetch_request_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.flush(flush),
		.lookup(lookup_bus.requester),
		.refill_start(refill_start),
		.refill_addr(refill_addr),
		.refill_done(refill_done),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.take(take),
		.use_fill(use_fill),
		.sel_way(sel_way),
		.offset(offset)
	);

	tag_store #(.WAY_COUNT(WAY_COUNT)) tag_store_i (
		.clk(clk),
		.rst(rst),
		.lookup(lookup_bus.responder),
		.fill(fill_bus.tag)
	);

	// The line read uses the index of the held request
	line_store #(.WAY_COUNT(WAY_COUNT)) line_store_i (
		.clk(clk),
		.index(lookup_bus.index),
		.fill(fill_bus.line),
		.rd_lines(rd_lines)
	);

	refill_master refill_master_i (
		.clk(clk),
		.rst(rst),
		.refill_start(refill_start),
		.refill_addr(refill_addr),
		.refill_done(refill_done),
		.fill(fill_bus.master),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.wb_sel(wb_sel)
	);

	word_select #(.WAY_COUNT(WAY_COUNT)) word_select_i (
		.clk(clk),
		.rst(rst),
		.rd_lines(rd_lines),
		.fill_line(fill_bus.fill_line),
		.sel_way(sel_way),
		.use_fill(use_fill),
		.offset(offset),
		.take(take),
		.flush(flush),
		.inst_ready(inst_ready),
		.inst_valid(inst_valid),
		.inst(inst)
	);

endmodule

/* source/line_store.sv */
module line_store #(
	parameter int WAY_COUNT = 4
) (
	input logic clk,
	input icache_pkg::index_t index,
	fill_if.line fill,
	output icache_pkg::line_t rd_lines [WAY_COUNT]
);

	icache_pkg::line_t data [WAY_COUNT][icache_pkg::SET_COUNT];

	// Fill writes go to the way picked by the tag store
	always_ff @(posedge clk) begin
		if (fill.fill_valid) begin
			for (int w = 0; w < WAY_COUNT; w++) begin
				if (fill.victim_way[w]) begin
					data[w][fill.fill_index] <= fill.fill_line;
				end
			end
		end
	end

	// Every way is read each cycle and the hit way is picked later
	always_ff @(posedge clk) begin
		for (int w = 0; w < WAY_COUNT; w++) begin
			rd_lines[w] <= data[w][index];
		end
	end

endmodule

/* source/refill_master.sv */
module refill_master (
	input logic clk,
	input logic rst,
	input logic refill_start,
	input icache_pkg::addr_t refill_addr,
	output logic refill_done,
	fill_if.master fill,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output icache_pkg::addr_t wb_adr,
	input icache_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output logic [3:0] wb_sel
);

	localparam int WORD_BITS = $bits(icache_pkg::word_t);
	localparam int LINE_BITS = $bits(icache_pkg::line_t);

	typedef enum logic [1:0] {
		rf_idle,
		rf_strobe,
		rf_gap
	} rf_state_t;

	rf_state_t state;
	icache_pkg::addr_t base_q;
	icache_pkg::offset_t beat;
	icache_pkg::line_t line_q;
	icache_pkg::line_t shifted;
	logic last_ack;

	assign wb_cyc = (state == rf_strobe);
	assign wb_stb = (state == rf_strobe);
	assign wb_we = 1'b0;
	assign wb_sel = '1;
	assign wb_adr = {base_q[31:4], beat, 2'b00};

	// Each acked word enters at the top, so word 0 ends in the low bits
	assign shifted = {wb_dat_i, line_q[LINE_BITS-1:WORD_BITS]};
	assign last_ack = (state == rf_strobe) && wb_ack
		&& (beat == icache_pkg::offset_t'(icache_pkg::LINE_BEATS - 1));

	assign refill_done = last_ack;
	assign fill.fill_valid = last_ack;
	assign fill.fill_index = base_q[9:4];
	assign fill.fill_tag = base_q[31:10];
	// The line is complete with the bus word during the last ack
	assign fill.fill_line = last_ack ? shifted : line_q;

	always_ff @(posedge clk) begin
		if (state == rf_idle && refill_start) begin
			base_q <= refill_addr;
		end
		if (state == rf_strobe && wb_ack) begin
			line_q <= shifted;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rf_idle;
			beat <= '0;
		end else begin
			case (state)
				rf_idle: begin
					if (refill_start) begin
						beat <= '0;
						state <= rf_strobe;
					end
				end
				rf_strobe: begin
					if (last_ack) begin
						state <= rf_idle;
					end else if (wb_ack) begin
						beat <= beat + 2'd1;
						state <= rf_gap;
					end
				end
				// The classic cycle ends here and the next beat starts fresh
				rf_gap: begin
					state <= rf_strobe;
				end
				default: begin
					state <= rf_idle;
				end
			endcase
		end
	end

endmodule

/* source/tag_store.sv */
module tag_store #(
	parameter int WAY_COUNT = 4
) (
	input logic clk,
	input logic rst,
	lookup_if.responder lookup,
	fill_if.tag fill
);

	icache_pkg::tag_t tags [WAY_COUNT][icache_pkg::SET_COUNT];
	logic [icache_pkg::SET_COUNT-1:0] valid [WAY_COUNT];
	icache_pkg::way_mask_t victim_ptr;
	icache_pkg::way_mask_t hit;

	// All ways compare in parallel
	always_comb begin
		hit = '0;
		for (int w = 0; w < WAY_COUNT; w++) begin
			hit[w] = lookup.lookup_valid && valid[w][lookup.index]
				&& (tags[w][lookup.index] == lookup.tag);
		end
	end

	assign lookup.hit_way = hit;
	assign lookup.miss = lookup.lookup_valid && (hit == '0);
	assign fill.victim_way = victim_ptr;

	// The fill writes its tag into the victim way
	always_ff @(posedge clk) begin
		if (fill.fill_valid) begin
			for (int w = 0; w < WAY_COUNT; w++) begin
				if (victim_ptr[w]) begin
					tags[w][fill.fill_index] <= fill.fill_tag;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAY_COUNT; w++) begin
				valid[w] <= '0;
			end
		end else if (fill.fill_valid) begin
			for (int w = 0; w < WAY_COUNT; w++) begin
				if (victim_ptr[w]) begin
					valid[w][fill.fill_index] <= 1'b1;
				end
			end
		end
	end

	// Round robin victim that wraps after the last way in use
	always_ff @(posedge clk) begin
		if (rst) begin
			victim_ptr <= icache_pkg::way_mask_t'(1);
		end else if (fill.fill_valid) begin
			if (victim_ptr[WAY_COUNT-1]) begin
				victim_ptr <= icache_pkg::way_mask_t'(1);
			end else begin
				victim_ptr <= victim_ptr << 1;
			end
		end
	end

endmodule

/* source/word_select.sv */
module word_select #(
	parameter int WAY_COUNT = 4
) (
	input logic clk,
	input logic rst,
	input icache_pkg::line_t rd_lines [WAY_COUNT],
	input icache_pkg::line_t fill_line,
	input icache_pkg::way_mask_t sel_way,
	input logic use_fill,
	input icache_pkg::offset_t offset,
	input logic take,
	input logic flush,
	input logic inst_ready,
	output logic inst_valid,
	output icache_pkg::word_t inst
);

	localparam int WORD_BITS = $bits(icache_pkg::word_t);

	icache_pkg::line_t line_sel;
	icache_pkg::word_t word;

	// The select is one-hot, so an OR of the masked ways is enough
	always_comb begin
		line_sel = '0;
		if (use_fill) begin
			line_sel = fill_line;
		end else begin
			for (int w = 0; w < WAY_COUNT; w++) begin
				if (sel_way[w]) begin
					line_sel = line_sel | rd_lines[w];
				end
			end
		end
	end

	assign word = line_sel[offset * WORD_BITS +: WORD_BITS];

	// The word is loaded only while no response is pending, so it holds under stall
	always_ff @(posedge clk) begin
		if (take) begin
			inst <= word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
		end else if (flush) begin
			inst_valid <= 1'b0;
		end else if (take) begin
			inst_valid <= 1'b1;
		end else if (inst_ready) begin
			inst_valid <= 1'b0;
		end
	end

endmodule
